//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pagerank_cu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- pagerank_cu.sv
// PageRank compute unit top level
// Vertex and command buffers, read arbitration and return-data routing
`include "pagerank_params.svh"

module pagerank_cu (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_job_valid,
	input  pagerank_pkg::vertex_job_t vertex_job,
	input  logic                      read_command_bus_grant,
	input  logic                      read_data_valid,
	input  pagerank_pkg::req_kind_t   read_data_kind,
	input  logic [`PR_RANK_W-1:0]     read_data_word,
	output logic                      vertex_job_request,
	output logic                      read_command_bus_request,
	output logic                      read_command_valid,
	output pagerank_pkg::read_cmd_t   read_command,
	output logic                      rank_write_valid,
	output pagerank_pkg::rank_write_t rank_write,
	output logic [`PR_VERTEX_W-1:0]   vertex_count,
	output logic [`PR_ADDR_W-1:0]     edge_count
);

	import pagerank_pkg::*;

	vertex_job_t             job_head;
	logic                    job_empty;
	logic                    job_pop;
	vertex_job_t             current_job;
	logic                    current_valid;
	logic                    vertex_done;
	logic                    edge_cmd_req;
	read_cmd_t               edge_cmd;
	logic                    edge_cmd_grant;
	logic                    rank_cmd_req;
	read_cmd_t               rank_cmd;
	logic                    rank_cmd_grant;
	logic                    neighbor_pop;
	logic                    neighbor_valid;
	logic [`PR_VERTEX_W-1:0] neighbor_id;
	logic                    rank_valid;
	logic [`PR_RANK_W-1:0]   rank;
	logic                    cmd_push;
	read_cmd_t               cmd_in;
	read_cmd_t               cmd_head;
	logic                    cmd_empty;
	logic                    cmd_almost_full;

	//////////////////////////////////////////////////////////////////////
	// Vertex intake
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.T     (vertex_job_t),
		.DEPTH (`PR_VERTEX_DEPTH)
	) i_vertex_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (vertex_job_valid),
		.data_in     (vertex_job),
		.pop         (job_pop),
		.data_out    (job_head),
		.empty       (job_empty),
		.full        (),
		.almost_full ()
	);

	assign vertex_job_request = job_empty;

	vertex_sequencer i_sequencer (
		.clock          (clock),
		.rstn           (rstn),
		.job_empty      (job_empty),
		.job_head       (job_head),
		.neighbor_pop   (neighbor_pop),
		.vertex_done    (vertex_done),
		.edge_cmd_grant (edge_cmd_grant),
		.job_pop        (job_pop),
		.current_job    (current_job),
		.current_valid  (current_valid),
		.edge_cmd_req   (edge_cmd_req),
		.edge_cmd       (edge_cmd)
	);

	rank_read_issuer i_issuer (
		.clock          (clock),
		.rstn           (rstn),
		.neighbor_valid (neighbor_valid),
		.neighbor_id    (neighbor_id),
		.rank_cmd_grant (rank_cmd_grant),
		.rank_cmd_req   (rank_cmd_req),
		.rank_cmd       (rank_cmd),
		.neighbor_pop   (neighbor_pop)
	);

	rank_sum_kernel i_sum_kernel (
		.clock            (clock),
		.rstn             (rstn),
		.current_job      (current_job),
		.current_valid    (current_valid),
		.rank_valid       (rank_valid),
		.rank             (rank),
		.vertex_done      (vertex_done),
		.rank_write_valid (rank_write_valid),
		.rank_write       (rank_write),
		.vertex_count     (vertex_count),
		.edge_count       (edge_count)
	);

	//////////////////////////////////////////////////////////////////////
	// Command path
	//////////////////////////////////////////////////////////////////////

	rr_command_arbiter i_arbiter (
		.clock           (clock),
		.rstn            (rstn),
		.edge_cmd_req    (edge_cmd_req),
		.edge_cmd        (edge_cmd),
		.rank_cmd_req    (rank_cmd_req),
		.rank_cmd        (rank_cmd),
		.cmd_almost_full (cmd_almost_full),
		.edge_cmd_grant  (edge_cmd_grant),
		.rank_cmd_grant  (rank_cmd_grant),
		.cmd_push        (cmd_push),
		.cmd_out         (cmd_in)
	);

	sync_fifo #(
		.T     (read_cmd_t),
		.DEPTH (`PR_CMD_DEPTH)
	) i_cmd_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (cmd_push),
		.data_in     (cmd_in),
		.pop         (read_command_bus_grant),
		.data_out    (cmd_head),
		.empty       (cmd_empty),
		.full        (),
		.almost_full (cmd_almost_full)
	);

	assign read_command_bus_request = !cmd_empty;

	// Grant on an empty buffer yields no command
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
		end else begin
			read_command_valid <= read_command_bus_grant && !cmd_empty;
		end
	end

	always_ff @(posedge clock) begin
		read_command <= cmd_head;
	end

	//////////////////////////////////////////////////////////////////////
	// Return data routing by kind tag
	//////////////////////////////////////////////////////////////////////

	assign neighbor_valid = read_data_valid && (read_data_kind == EDGE_LIST);
	assign neighbor_id    = read_data_word[`PR_VERTEX_W-1:0];
	assign rank_valid     = read_data_valid && (read_data_kind == VERTEX_RANK);
	assign rank           = read_data_word;

endmodule

//--- pagerank_params.svh
// PageRank compute unit sizes
// Widths of ids, degrees, addresses and ranks, plus buffer depths
`ifndef PAGERANK_PARAMS_SVH
`define PAGERANK_PARAMS_SVH

// Data path widths
`define PR_VERTEX_W 16
`define PR_DEGREE_W 8
`define PR_ADDR_W 16
`define PR_RANK_W 32

// Buffer depths
`define PR_VERTEX_DEPTH 8
`define PR_CMD_DEPTH 16

// Neighbor buffer depth, doubles as the edge-read credit limit
`define PR_NEIGHBOR_DEPTH 8

`endif

//--- pagerank_pkg.sv
// PageRank compute unit shared types
// Vertex jobs, read commands with their kind tag, and rank writes
`include "pagerank_params.svh"

package pagerank_pkg;

	// Tag carried by every read command and its returned word
	typedef enum logic {
		EDGE_LIST   = 1'b0,
		VERTEX_RANK = 1'b1
	} req_kind_t;

	typedef struct packed {
		logic [`PR_VERTEX_W-1:0] vertex_id;
		logic [`PR_DEGREE_W-1:0] out_degree;
		logic [`PR_ADDR_W-1:0]   base_addr;
	} vertex_job_t;

	typedef struct packed {
		req_kind_t             kind;
		logic [`PR_ADDR_W-1:0] addr;
	} read_cmd_t;

	typedef struct packed {
		logic [`PR_VERTEX_W-1:0] vertex_id;
		logic [`PR_RANK_W-1:0]   sum;
	} rank_write_t;

endpackage

//--- rank_read_issuer.sv
// Rank read issuer
// Buffers returned neighbor ids and offers each one as a rank read
`include "pagerank_params.svh"

module rank_read_issuer (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    neighbor_valid,
	input  logic [`PR_VERTEX_W-1:0] neighbor_id,
	input  logic                    rank_cmd_grant,
	output logic                    rank_cmd_req,
	output pagerank_pkg::read_cmd_t rank_cmd,
	output logic                    neighbor_pop
);

	import pagerank_pkg::*;

	localparam int ADDR_W = `PR_ADDR_W;

	logic [`PR_VERTEX_W-1:0] head_id;
	logic                    head_empty;

	// Sized by the sequencer credit limit, so it never overflows
	sync_fifo #(
		.T     (logic [`PR_VERTEX_W-1:0]),
		.DEPTH (`PR_NEIGHBOR_DEPTH)
	) i_neighbor_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (neighbor_valid),
		.data_in     (neighbor_id),
		.pop         (neighbor_pop),
		.data_out    (head_id),
		.empty       (head_empty),
		.full        (),
		.almost_full ()
	);

	// Rank of vertex v lives at word address v
	assign rank_cmd_req  = !head_empty;
	assign rank_cmd.kind = VERTEX_RANK;
	assign rank_cmd.addr = ADDR_W'(head_id);

	assign neighbor_pop = rank_cmd_grant && !head_empty;

endmodule

//--- rank_sum_kernel.sv
// Rank sum kernel
// Adds neighbor ranks per vertex, emits rank writes and keeps the counters
`include "pagerank_params.svh"

module rank_sum_kernel (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::vertex_job_t current_job,
	input  logic                      current_valid,
	input  logic                      rank_valid,
	input  logic [`PR_RANK_W-1:0]     rank,
	output logic                      vertex_done,
	output logic                      rank_write_valid,
	output pagerank_pkg::rank_write_t rank_write,
	output logic [`PR_VERTEX_W-1:0]   vertex_count,
	output logic [`PR_ADDR_W-1:0]     edge_count
);

	logic [`PR_RANK_W-1:0]   acc;
	logic [`PR_RANK_W-1:0]   acc_next;
	logic [`PR_DEGREE_W-1:0] rank_cnt;
	logic [`PR_DEGREE_W-1:0] cnt_next;
	logic                    complete;

	// Sum wraps at PR_RANK_W
	assign acc_next = rank_valid ? acc + rank : acc;
	assign cnt_next = rank_valid ? rank_cnt + 1'b1 : rank_cnt;

	// Also fires for a zero-degree vertex with no ranks at all
	// vertex_done masks the cycle before the sequencer releases the vertex
	assign complete = current_valid && !vertex_done &&
		(cnt_next == current_job.out_degree);

	assign rank_write_valid = vertex_done;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			acc          <= '0;
			rank_cnt     <= '0;
			vertex_done  <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			vertex_done <= complete;
			if (complete) begin
				acc          <= '0;
				rank_cnt     <= '0;
				vertex_count <= vertex_count + 1'b1;
			end else begin
				acc      <= acc_next;
				rank_cnt <= cnt_next;
			end
			if (rank_valid) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	// Result word, valid with vertex_done
	always_ff @(posedge clock) begin
		if (complete) begin
			rank_write.vertex_id <= current_job.vertex_id;
			rank_write.sum       <= acc_next;
		end
	end

endmodule

//--- rr_command_arbiter.sv
// Two-input round-robin arbiter for read commands
// Admits at most one command per cycle into the command buffer
module rr_command_arbiter (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    edge_cmd_req,
	input  pagerank_pkg::read_cmd_t edge_cmd,
	input  logic                    rank_cmd_req,
	input  pagerank_pkg::read_cmd_t rank_cmd,
	input  logic                    cmd_almost_full,
	output logic                    edge_cmd_grant,
	output logic                    rank_cmd_grant,
	output logic                    cmd_push,
	output pagerank_pkg::read_cmd_t cmd_out
);

	// Set when the rank side won the last grant
	logic last_rank;
	logic pick_rank;

	// Tie goes to whichever side lost last time
	always_comb begin
		if (edge_cmd_req && rank_cmd_req) begin
			pick_rank = !last_rank;
		end else begin
			pick_rank = rank_cmd_req;
		end
	end

	assign rank_cmd_grant = !cmd_almost_full && rank_cmd_req && pick_rank;
	assign edge_cmd_grant = !cmd_almost_full && edge_cmd_req && !pick_rank;
	assign cmd_push       = edge_cmd_grant || rank_cmd_grant;
	assign cmd_out        = pick_rank ? rank_cmd : edge_cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_rank <= 1'b0;
		end else if (cmd_push) begin
			last_rank <= rank_cmd_grant;
		end
	end

endmodule

//--- sim.f
+incdir+.
pagerank_pkg.sv
sync_fifo.sv
rr_command_arbiter.sv
vertex_sequencer.sv
rank_read_issuer.sv
rank_sum_kernel.sv
pagerank_cu.sv
tb_pagerank_cu.sv

//--- sync_fifo.sv
// Synchronous FIFO with a type-parameterized payload
// Head entry is always visible on data_out
module sync_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 8
) (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  T     data_in,
	input  logic pop,
	output T     data_out,
	output logic empty,
	output logic full,
	output logic almost_full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

	T              mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// Push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty       = (count == '0);
	assign full        = (count == CW'(DEPTH));
	assign almost_full = (count >= CW'(DEPTH - 1));
	assign data_out    = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

endmodule

//--- tb_pagerank_cu.sv
// PageRank compute unit testbench
// Directed tests against a graph memory model with random grants and latencies
`include "pagerank_params.svh"

module tb_pagerank_cu;

	import pagerank_pkg::*;

	localparam int RANK_SPAN = 256;

	logic                    clock;
	logic                    rstn;
	logic                    vertex_job_valid;
	vertex_job_t             vertex_job;
	logic                    read_command_bus_grant;
	logic                    read_data_valid;
	req_kind_t               read_data_kind;
	logic [`PR_RANK_W-1:0]   read_data_word;
	logic                    vertex_job_request;
	logic                    read_command_bus_request;
	logic                    read_command_valid;
	read_cmd_t               read_command;
	logic                    rank_write_valid;
	rank_write_t             rank_write;
	logic [`PR_VERTEX_W-1:0] vertex_count;
	logic [`PR_ADDR_W-1:0]   edge_count;

	// Graph image, indexed by word address
	logic [`PR_VERTEX_W-1:0] edge_mem [0:65535];
	logic [`PR_RANK_W-1:0]   rank_mem [0:65535];

	read_cmd_t   cmd_q [$];
	read_cmd_t   pend_cmd [$];
	int          pend_due [$];
	rank_write_t wr_q [$];

	logic [15:0] lfsr = 16'd77;
	int          cycle = 0;
	int          gap_bits = 1;
	int          lat_bits = 3;
	int          edge_lo = 0;
	int          edge_hi = 0;
	logic        force_grant = 1'b0;
	logic        model_idle = 1'b1;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          exp_vertices = 0;
	int          exp_edges = 0;

	pagerank_cu i_dut (
		.clock                    (clock),
		.rstn                     (rstn),
		.vertex_job_valid         (vertex_job_valid),
		.vertex_job               (vertex_job),
		.read_command_bus_grant   (read_command_bus_grant),
		.read_data_valid          (read_data_valid),
		.read_data_kind           (read_data_kind),
		.read_data_word           (read_data_word),
		.vertex_job_request       (vertex_job_request),
		.read_command_bus_request (read_command_bus_request),
		.read_command_valid       (read_command_valid),
		.read_command             (read_command),
		.rank_write_valid         (rank_write_valid),
		.rank_write               (rank_write),
		.vertex_count             (vertex_count),
		.edge_count               (edge_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Random bits, checks and waits
	//////////////////////////////////////////////////////////////////////

	function automatic logic next_random_bit();
		logic lsb;
		lsb = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return lsb;
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(next_random_bit());
		end
		return v;
	endfunction

	// Wrapping sum of the neighbor ranks of one vertex
	function automatic logic [`PR_RANK_W-1:0] expected_sum(input int base, input int deg);
		logic [`PR_RANK_W-1:0] s;
		s = '0;
		for (int k = 0; k < deg; k++) begin
			s = s + rank_mem[edge_mem[16'(base + k)]];
		end
		return s;
	endfunction

	task automatic compare(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("test %s finished with %0d errors", name, errors - errs_before);
	endtask

	task automatic wait_writes(input int n, input int limit);
		int waited;
		waited = 0;
		while (wr_q.size() < n && waited < limit) begin
			@(posedge clock);
			waited++;
		end
		if (wr_q.size() < n) begin
			report_failure($sformatf("no %0d rank writes within %0d cycles", n, limit));
		end
	endtask

	task automatic wait_quiet(input int limit);
		int waited;
		waited = 0;
		@(posedge clock);
		while (!model_idle && waited < limit) begin
			@(posedge clock);
			waited++;
		end
		if (!model_idle) begin
			report_failure("memory traffic did not settle");
		end
	endtask

	task automatic push_job(input logic [15:0] vid, input logic [7:0] deg,
		input logic [15:0] base);
		@(negedge clock);
		vertex_job_valid = 1'b1;
		vertex_job.vertex_id = vid;
		vertex_job.out_degree = deg;
		vertex_job.base_addr = base;
		@(negedge clock);
		vertex_job_valid = 1'b0;
	endtask

	task automatic check_write(input int idx, input logic [15:0] vid,
		input logic [`PR_RANK_W-1:0] sum);
		if (wr_q.size() > idx) begin
			compare("rank_write.vertex_id", 64'(wr_q[idx].vertex_id), 64'(vid));
			compare("rank_write.sum", 64'(wr_q[idx].sum), 64'(sum));
		end
	endtask

	task automatic check_counters();
		compare("vertex_count", 64'(vertex_count), 64'(exp_vertices));
		compare("edge_count", 64'(edge_count), 64'(exp_edges));
	endtask

	// Edge reads in walk order, rank reads as a multiset of neighbor ids
	task automatic check_read_commands(input int base, input int deg);
		int edge_seen [$];
		int rank_seen [$];
		int rank_exp [$];
		foreach (cmd_q[i]) begin
			if (cmd_q[i].kind == EDGE_LIST) begin
				edge_seen.push_back(int'(cmd_q[i].addr));
			end else begin
				rank_seen.push_back(int'(cmd_q[i].addr));
			end
		end
		for (int k = 0; k < deg; k++) begin
			rank_exp.push_back(int'(edge_mem[16'(base + k)]));
		end
		rank_seen.sort();
		rank_exp.sort();
		compare("edge read count", 64'(edge_seen.size()), 64'(deg));
		compare("rank read count", 64'(rank_seen.size()), 64'(deg));
		if (edge_seen.size() == deg && rank_seen.size() == deg) begin
			for (int k = 0; k < deg; k++) begin
				compare("edge read addr", 64'(edge_seen[k]), 64'(base + k));
				compare("rank read addr", 64'(rank_seen[k]), 64'(rank_exp[k]));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	initial begin : memory_model
		int pick;
		int gap;
		logic [15:0] a16;
		read_command_bus_grant = 1'b0;
		read_data_valid = 1'b0;
		read_data_kind = EDGE_LIST;
		read_data_word = '0;
		gap = 0;
		// Neighbor ids stay below RANK_SPAN, ranks are large so sums wrap
		for (int a = 0; a < 65536; a++) begin
			edge_mem[16'(a)] = 16'((((a >> 8) ^ a) * 37 + 11) % RANK_SPAN);
			rank_mem[16'(a)] = 32'hC000_0000 ^ (32'(a) * 32'h0101_0101);
		end
		forever begin
			@(negedge clock);
			cycle++;
			if (read_command_valid) begin
				cmd_q.push_back(read_command);
				pend_cmd.push_back(read_command);
				pend_due.push_back(cycle + 1 + random_bits(lat_bits));
				if (read_command.kind == EDGE_LIST && (int'(read_command.addr) < edge_lo ||
					int'(read_command.addr) >= edge_hi)) begin
					report_failure($sformatf("edge read at %0h is outside the edge list",
						read_command.addr));
				end
				if (read_command.kind == VERTEX_RANK && int'(read_command.addr) >= RANK_SPAN) begin
					report_failure($sformatf("rank read at %0h is not a vertex", read_command.addr));
				end
			end
			if (rank_write_valid) begin
				wr_q.push_back(rank_write);
			end
			// One returned word per cycle, oldest due first
			pick = -1;
			foreach (pend_due[i]) begin
				if (pick < 0 && pend_due[i] <= cycle) begin
					pick = i;
				end
			end
			read_data_valid = 1'b0;
			if (pick >= 0) begin
				a16 = pend_cmd[pick].addr;
				read_data_valid = 1'b1;
				read_data_kind = pend_cmd[pick].kind;
				if (pend_cmd[pick].kind == EDGE_LIST) begin
					read_data_word = 32'(edge_mem[a16]);
				end else begin
					read_data_word = rank_mem[a16];
				end
				pend_cmd.delete(pick);
				pend_due.delete(pick);
			end
			if (force_grant) begin
				read_command_bus_grant = 1'b1;
			end else if (read_command_bus_request && gap == 0) begin
				read_command_bus_grant = 1'b1;
				gap = random_bits(gap_bits);
			end else begin
				read_command_bus_grant = 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end
			model_idle = (pend_due.size() == 0) && !read_command_bus_request &&
				!read_command_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		int errs_before;
		errs_before = errors;
		compare("read_command_bus_request", 64'(read_command_bus_request), 64'(0));
		compare("read_command_valid", 64'(read_command_valid), 64'(0));
		compare("rank_write_valid", 64'(rank_write_valid), 64'(0));
		compare("vertex_job_request", 64'(vertex_job_request), 64'(1));
		check_counters();
		// Grant pulse with nothing queued
		@(posedge clock);
		force_grant = 1'b1;
		@(posedge clock);
		force_grant = 1'b0;
		@(negedge clock);
		compare("read_command_valid", 64'(read_command_valid), 64'(0));
		finish_test("reset_state", errs_before);
	endtask

	task automatic test_single_vertex();
		int errs_before;
		errs_before = errors;
		@(posedge clock);
		cmd_q.delete();
		wr_q.delete();
		edge_lo = 'h0010;
		edge_hi = 'h0013;
		push_job(16'h0042, 8'd3, 16'h0010);
		wait_writes(1, 2000);
		wait_quiet(2000);
		exp_vertices += 1;
		exp_edges += 3;
		check_write(0, 16'h0042, expected_sum('h0010, 3));
		compare("rank write count", 64'(wr_q.size()), 64'(1));
		check_read_commands('h0010, 3);
		check_counters();
		finish_test("single_vertex", errs_before);
	endtask

	task automatic test_zero_degree();
		int errs_before;
		errs_before = errors;
		@(posedge clock);
		cmd_q.delete();
		wr_q.delete();
		push_job(16'h0055, 8'd0, 16'h0020);
		wait_writes(1, 200);
		wait_quiet(200);
		exp_vertices += 1;
		check_write(0, 16'h0055, '0);
		compare("rank write count", 64'(wr_q.size()), 64'(1));
		compare("read command count", 64'(cmd_q.size()), 64'(0));
		check_counters();
		finish_test("zero_degree", errs_before);
	endtask

	task automatic test_vertex_burst();
		int errs_before;
		int deg [6];
		int base [6];
		int total;
		errs_before = errors;
		@(posedge clock);
		wr_q.delete();
		gap_bits = 3;
		lat_bits = 4;
		total = 0;
		for (int j = 0; j < 6; j++) begin
			deg[j] = random_bits(4) % 13;
			base[j] = 'h0040 + total;
			total += deg[j];
		end
		edge_lo = 'h0040;
		edge_hi = 'h0040 + total;
		for (int j = 0; j < 6; j++) begin
			push_job(16'('h0100 + j), 8'(deg[j]), 16'(base[j]));
		end
		wait_writes(6, 20000);
		wait_quiet(2000);
		exp_vertices += 6;
		exp_edges += total;
		compare("rank write count", 64'(wr_q.size()), 64'(6));
		for (int j = 0; j < 6; j++) begin
			check_write(j, 16'('h0100 + j), expected_sum(base[j], deg[j]));
		end
		check_counters();
		gap_bits = 1;
		lat_bits = 3;
		finish_test("vertex_burst", errs_before);
	endtask

	task automatic test_job_request();
		int errs_before;
		int waited;
		errs_before = errors;
		@(posedge clock);
		wr_q.delete();
		edge_lo = 'h0030;
		edge_hi = 'h0032;
		@(negedge clock);
		compare("vertex_job_request", 64'(vertex_job_request), 64'(1));
		push_job(16'h0077, 8'd2, 16'h0030);
		compare("vertex_job_request", 64'(vertex_job_request), 64'(0));
		waited = 0;
		while (!vertex_job_request && waited < 100) begin
			@(negedge clock);
			waited++;
		end
		if (!vertex_job_request) begin
			report_failure("vertex_job_request stayed low after the job was taken");
		end
		wait_writes(1, 2000);
		wait_quiet(2000);
		exp_vertices += 1;
		exp_edges += 2;
		check_write(0, 16'h0077, expected_sum('h0030, 2));
		compare("rank write count", 64'(wr_q.size()), 64'(1));
		check_counters();
		finish_test("job_request", errs_before);
	endtask

	initial begin
		rstn = 1'b0;
		vertex_job_valid = 1'b0;
		vertex_job = '0;
		repeat (16) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		test_reset_state();
		test_single_vertex();
		test_zero_degree();
		test_vertex_burst();
		test_job_request();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- vertex_sequencer.sv
// Vertex sequencer, one vertex at a time
// Walks the out-edge list and issues edge-list reads under a credit limit
`include "pagerank_params.svh"

module vertex_sequencer (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_empty,
	input  pagerank_pkg::vertex_job_t job_head,
	input  logic                      neighbor_pop,
	input  logic                      vertex_done,
	input  logic                      edge_cmd_grant,
	output logic                      job_pop,
	output pagerank_pkg::vertex_job_t current_job,
	output logic                      current_valid,
	output logic                      edge_cmd_req,
	output pagerank_pkg::read_cmd_t   edge_cmd
);

	import pagerank_pkg::*;

	localparam int ADDR_W = `PR_ADDR_W;
	localparam int CRW    = $clog2(`PR_NEIGHBOR_DEPTH + 1);

	logic [`PR_DEGREE_W-1:0] edge_idx;
	logic [CRW-1:0]          credits;
	logic                    walk_done;
	logic                    credit_ok;

	// Take the next job as soon as the slot is free
	assign job_pop = !current_valid && !job_empty;

	assign walk_done    = (edge_idx == current_job.out_degree);
	assign credit_ok    = (credits < CRW'(`PR_NEIGHBOR_DEPTH));
	assign edge_cmd_req = current_valid && !walk_done && credit_ok;

	assign edge_cmd.kind = EDGE_LIST;
	assign edge_cmd.addr = current_job.base_addr + ADDR_W'(edge_idx);

	//////////////////////////////////////////////////////////////////////
	// Current vertex and edge walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_valid <= 1'b0;
			edge_idx      <= '0;
		end else if (job_pop) begin
			current_valid <= 1'b1;
			edge_idx      <= '0;
		end else begin
			if (vertex_done) begin
				current_valid <= 1'b0;
			end
			if (edge_cmd_grant) begin
				edge_idx <= edge_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop) begin
			current_job <= job_head;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Edge-read credits
	//////////////////////////////////////////////////////////////////////

	// Reads issued whose neighbor has not yet left the neighbor buffer
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= '0;
		end else begin
			case ({edge_cmd_grant, neighbor_pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule
